// File: src.f
logic/mmu_tx_reg_pkg.sv
logic/mmu_tx_bus_port.sv
logic/mmu_tx_cfg_err_regs.sv
logic/mmu_tx_event_counters.sv
logic/mmu_tx_read_mux.sv
logic/mmu_tx_regs.sv
verification/mmu_tx_regs_checker.sv
verification/tb_clk_gen.sv
verification/mmu_tx_regs_tb.sv

// File: Makefile
TOP = mmu_tx_regs_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/mmu_tx_regs_tb.sv
`timescale 1ns/1ns

module mmu_tx_regs_tb;

        import mmu_tx_reg_pkg::*;

        localparam block_id_t   BLOCK_ID    = 12'h001;
        localparam int          DDR_NUM     = 4;
        localparam int          N_SINGLE    = 11;
        localparam int          N_CNT       = N_SINGLE + 4 * DDR_NUM;
        localparam int          ACK_TIMEOUT = 20;
        localparam logic [10:0] BEAT_RESET  = 11'h350;

        logic        clk_sys;
        logic        rst;
        logic        wb_cyc;
        logic        wb_stb;
        logic        wb_we;
        reg_addr_t   wb_adr;
        reg_data_t   wb_dat_w;
        reg_data_t   wb_dat_r;
        logic        wb_ack;
        tx_status_t  status;
        tx_errors_t  errors;
        tx_events_t  events;
        ddr_events_t ddr_events [DDR_NUM];
        logic        cnt_clr;
        logic [10:0] online_beat_cfg;

        int          error_count;
        int          timeout_count;
        logic [31:0] rng;
        logic [10:0] beat_model;
        reg_data_t   cnt_model [N_CNT];

        tb_clk_gen u_clk_gen (
                .clk_sys (clk_sys)
        );

        mmu_tx_regs #(
                .BLOCK_ID (BLOCK_ID),
                .DDR_NUM  (DDR_NUM)
        ) u_mmu_tx_regs (
                .clk_sys         (clk_sys),
                .rst             (rst),
                .wb_cyc          (wb_cyc),
                .wb_stb          (wb_stb),
                .wb_we           (wb_we),
                .wb_adr          (wb_adr),
                .wb_dat_w        (wb_dat_w),
                .wb_dat_r        (wb_dat_r),
                .wb_ack          (wb_ack),
                .status          (status),
                .errors          (errors),
                .events          (events),
                .ddr_events      (ddr_events),
                .cnt_clr         (cnt_clr),
                .online_beat_cfg (online_beat_cfg)
        );

        //**************************************************
        // helpers
        //**************************************************
        function automatic logic [31:0] xorshift32(input logic [31:0] x);
                x = x ^ (x << 13);
                x = x ^ (x >> 17);
                x = x ^ (x << 5);
                return x;
        endfunction

        function automatic reg_addr_t make_addr(input reg_group_e grp, input reg_index_t idx);
                reg_addr_t a;
                a.block_id = BLOCK_ID;
                a.rsvd     = 3'd0;
                a.group    = grp;
                a.index    = idx;
                return a;
        endfunction

        // singles at 0..10, channel c kind k at 0x10 + 4c + k
        function automatic reg_index_t cnt_index(input int n);
                if (n < N_SINGLE) begin
                        return reg_index_t'(n);
                end
                return reg_index_t'(16 + n - N_SINGLE);
        endfunction

        task automatic wait_ack();
                int  n;
                bit  got;
                n   = 0;
                got = 1'b0;
                while (!got && n < ACK_TIMEOUT) begin
                        @(negedge clk_sys);
                        if (wb_ack) begin
                                got = 1'b1;
                        end else begin
                                n++;
                        end
                end
                if (!got) begin
                        timeout_count++;
                        $display("no ack within %0d cycles at %0t", ACK_TIMEOUT, $time);
                end
        endtask

        // master keeps stb through the ack edge, drops it on the next falling edge
        task automatic wb_write(input reg_addr_t adr, input reg_data_t data);
                @(negedge clk_sys);
                wb_cyc   = 1'b1;
                wb_stb   = 1'b1;
                wb_we    = 1'b1;
                wb_adr   = adr;
                wb_dat_w = data;
                wait_ack();
                @(negedge clk_sys);
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we  = 1'b0;
        endtask

        task automatic wb_read(input reg_addr_t adr, output reg_data_t data);
                @(negedge clk_sys);
                wb_cyc = 1'b1;
                wb_stb = 1'b1;
                wb_we  = 1'b0;
                wb_adr = adr;
                wait_ack();
                data = wb_dat_r;
                @(negedge clk_sys);
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
        endtask

        task automatic check_data(input reg_data_t got, input reg_data_t exp, input string what);
                if (got !== exp) begin
                        error_count++;
                        $display("FAIL %0t: %s read %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic check_beat(input logic [10:0] got, input logic [10:0] exp,
                                  input string what);
                if (got !== exp) begin
                        error_count++;
                        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic read_expect(input reg_addr_t adr, input reg_data_t exp, input string what);
                reg_data_t data;
                wb_read(adr, data);
                check_data(data, exp, what);
        endtask

        task automatic read_all_counters(input string what);
                for (int n = 0; n < N_CNT; n++) begin
                        read_expect(make_addr(grp_cnt, cnt_index(n)), cnt_model[n],
                                    $sformatf("%s counter %0d", what, n));
                end
        endtask

        //**************************************************
        // directed tests
        //**************************************************
        task automatic test_reset();
                check_beat(online_beat_cfg, BEAT_RESET, "online beat after reset");
                read_expect(make_addr(grp_cfg, 7'd0), 32'h350, "cfg beat limit");
                read_expect(make_addr(grp_err, 7'd0), '0, "pkt err after reset");
                read_expect(make_addr(grp_err, 7'd1), '0, "bd err after reset");
                for (int n = 0; n < N_CNT; n++) begin
                        cnt_model[n] = '0;
                end
                read_all_counters("reset");
                read_expect(make_addr(grp_cfg, 7'd1), '0, "unmapped cfg");
        endtask

        task automatic test_cfg_write();
                wb_write(make_addr(grp_cfg, 7'd0), 32'habcd_e7a5);
                beat_model = 11'h7a5;
                read_expect(make_addr(grp_cfg, 7'd0), {21'd0, beat_model}, "cfg read back");
                check_beat(online_beat_cfg, beat_model, "online beat after write");
        endtask

        task automatic test_errors();
                @(negedge clk_sys);
                errors.pkt_err = 32'h8001_0204;
                errors.bd_err  = 16'hc003;
                @(negedge clk_sys);
                errors = '0;
                read_expect(make_addr(grp_err, 7'd0), 32'h8001_0204, "pkt err sticky");
                read_expect(make_addr(grp_err, 7'd1), 32'h0000_c003, "bd err sticky");
                read_expect(make_addr(grp_err, 7'd2), '0, "unmapped err");
                wb_write(make_addr(grp_err, 7'd0), 32'h0000_0200);
                read_expect(make_addr(grp_err, 7'd0), 32'h8001_0004, "pkt err bit 9 cleared");
                wb_write(make_addr(grp_err, 7'd1), 32'h0000_4000);
                read_expect(make_addr(grp_err, 7'd1), 32'h0000_8003, "bd err bit 14 cleared");
                // upper half of the write is outside the 16-bit register
                wb_write(make_addr(grp_err, 7'd1), 32'hffff_0001);
                read_expect(make_addr(grp_err, 7'd1), 32'h0000_8002, "bd err bit 0 cleared");
        endtask

        task automatic test_status();
                @(negedge clk_sys);
                status.pkt_sta     = 32'h1234_5678;
                status.bd_sta      = 16'hbeef;
                status.ddr_rsp_sn  = 11'h5a5;
                status.seq_info    = 3'h6;
                status.online_beat = 11'h2c3;
                status.hacc_sn     = 11'h7ff;
                read_expect(make_addr(grp_sta, 7'd0), 32'h1234_5678, "pkt_sta");
                read_expect(make_addr(grp_sta, 7'd1), 32'h0000_beef, "bd_sta");
                read_expect(make_addr(grp_sta, 7'd2), 32'h0000_05a5, "ddr_rsp_sn");
                read_expect(make_addr(grp_sta, 7'd3), 32'h0000_0006, "seq_info");
                read_expect(make_addr(grp_sta, 7'd4), 32'h0000_02c3, "online_beat status");
                read_expect(make_addr(grp_sta, 7'd5), 32'h0000_07ff, "hacc_sn");
                read_expect(make_addr(grp_sta, 7'd6), '0, "unmapped sta");
        endtask

        // bit n of the random word pulses flat counter n
        task automatic test_counters();
                for (int i = 0; i < 200; i++) begin
                        @(negedge clk_sys);
                        rng    = xorshift32(rng);
                        events = tx_events_t'(rng[N_SINGLE-1:0]);
                        for (int c = 0; c < DDR_NUM; c++) begin
                                ddr_events[c] = ddr_events_t'(rng[N_SINGLE + 4 * c +: 4]);
                        end
                        for (int n = 0; n < N_CNT; n++) begin
                                if (rng[n]) begin
                                        cnt_model[n] = cnt_model[n] + 32'd1;
                                end
                        end
                end
                @(negedge clk_sys);
                events = '0;
                for (int c = 0; c < DDR_NUM; c++) begin
                        ddr_events[c] = '0;
                end
                read_all_counters("random");
                read_expect(make_addr(grp_cnt, 7'd11), '0, "unmapped cnt 0x0b");
                read_expect(make_addr(grp_cnt, reg_index_t'(16 + 4 * DDR_NUM)), '0,
                            "unmapped cnt after last channel");
                read_expect(make_addr(grp_cnt, 7'h7f), '0, "unmapped cnt 0x7f");
                @(negedge clk_sys);
                cnt_clr = 1'b1;
                @(negedge clk_sys);
                cnt_clr = 1'b0;
                for (int n = 0; n < N_CNT; n++) begin
                        cnt_model[n] = '0;
                end
                read_all_counters("cleared");
        endtask

        task automatic test_wrong_block();
                reg_addr_t a;
                a          = make_addr(grp_cfg, 7'd0);
                a.block_id = 12'h002;
                wb_write(a, 32'h0000_0111);
                read_expect(make_addr(grp_cfg, 7'd0), {21'd0, beat_model},
                            "cfg after foreign write");
                check_beat(online_beat_cfg, beat_model, "online beat after foreign write");
                read_expect(a, '0, "foreign block read");
                a          = make_addr(grp_cfg, 7'd0);
                a.rsvd     = 3'b010;
                read_expect(a, '0, "reserved bits read");
        endtask

        //**************************************************
        // main sequence
        //**************************************************
        initial begin
                rst           = 1'b1;
                wb_cyc        = 1'b0;
                wb_stb        = 1'b0;
                wb_we         = 1'b0;
                wb_adr        = '0;
                wb_dat_w      = '0;
                status        = '0;
                errors        = '0;
                events        = '0;
                cnt_clr       = 1'b0;
                error_count   = 0;
                timeout_count = 0;
                rng           = 32'd81;
                beat_model    = BEAT_RESET;
                for (int c = 0; c < DDR_NUM; c++) begin
                        ddr_events[c] = '0;
                end

                repeat (16) @(posedge clk_sys);
                @(negedge clk_sys);
                rst = 1'b0;

                test_reset();
                test_cfg_write();
                test_errors();
                test_status();
                test_counters();
                test_wrong_block();

                $display("errors: %0d  timeouts: %0d", error_count, timeout_count);
                if (error_count == 0 && timeout_count == 0) begin
                        $display("Result: PASSED");
                end else begin
                        $display("Result: FAILED");
                end
                $finish;
        end

endmodule

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
        parameter int PERIOD = 100
) (
        output logic clk_sys
);

        initial begin
                clk_sys = 1'b0;
        end

        always #(PERIOD / 2) clk_sys = ~clk_sys;

endmodule

// File: verification/mmu_tx_regs_checker.sv
`timescale 1ns/1ns

module mmu_tx_regs_checker (
        input logic clk_sys,
        input logic rst,
        input logic wb_cyc,
        input logic wb_stb,
        input logic wb_ack
);

        // ack only inside an open cycle with strobe
        ack_needs_req: assert property (
                @(posedge clk_sys) disable iff (rst) wb_ack |-> (wb_cyc && wb_stb)
        ) else $error("wb_ack high without wb_cyc and wb_stb");

        ack_one_cycle: assert property (
                @(posedge clk_sys) disable iff (rst) wb_ack |=> !wb_ack
        ) else $error("wb_ack held for more than one cycle");

        ack_low_in_reset: assert property (
                @(posedge clk_sys) rst |-> !wb_ack
        ) else $error("wb_ack high during reset");

endmodule

bind mmu_tx_regs mmu_tx_regs_checker u_checker (
        .clk_sys (clk_sys),
        .rst     (rst),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_ack  (wb_ack)
);

// File: logic/mmu_tx_regs.sv
`timescale 1ns/1ns

module mmu_tx_regs #(
        parameter mmu_tx_reg_pkg::block_id_t BLOCK_ID = 12'h001,
        parameter int                        DDR_NUM  = 4
) (
        input  logic                         clk_sys,
        input  logic                         rst,

        // wishbone slave
        input  logic                         wb_cyc,
        input  logic                         wb_stb,
        input  logic                         wb_we,
        input  mmu_tx_reg_pkg::reg_addr_t    wb_adr,
        input  mmu_tx_reg_pkg::reg_data_t    wb_dat_w,
        output mmu_tx_reg_pkg::reg_data_t    wb_dat_r,
        output logic                         wb_ack,

        // tx path
        input  mmu_tx_reg_pkg::tx_status_t   status,
        input  mmu_tx_reg_pkg::tx_errors_t   errors,
        input  mmu_tx_reg_pkg::tx_events_t   events,
        input  mmu_tx_reg_pkg::ddr_events_t  ddr_events [DDR_NUM],
        input  logic                         cnt_clr,
        output logic [10:0]                  online_beat_cfg
);

        import mmu_tx_reg_pkg::*;

        reg_req_t  req;
        reg_data_t cfg_rdata;
        reg_data_t err_rdata;
        reg_data_t cnt_rdata;

        mmu_tx_bus_port #(
                .BLOCK_ID (BLOCK_ID)
        ) u_bus_port (
                .clk_sys  (clk_sys),
                .rst      (rst),
                .wb_cyc   (wb_cyc),
                .wb_stb   (wb_stb),
                .wb_we    (wb_we),
                .wb_adr   (wb_adr),
                .wb_dat_w (wb_dat_w),
                .wb_ack   (wb_ack),
                .req      (req)
        );

        mmu_tx_cfg_err_regs u_cfg_err_regs (
                .clk_sys         (clk_sys),
                .rst             (rst),
                .req             (req),
                .errors          (errors),
                .online_beat_cfg (online_beat_cfg),
                .cfg_rdata       (cfg_rdata),
                .err_rdata       (err_rdata)
        );

        mmu_tx_event_counters #(
                .DDR_NUM (DDR_NUM)
        ) u_event_counters (
                .clk_sys    (clk_sys),
                .rst        (rst),
                .cnt_clr    (cnt_clr),
                .events     (events),
                .ddr_events (ddr_events),
                .rd_index   (req.index),
                .cnt_rdata  (cnt_rdata)
        );

        mmu_tx_read_mux u_read_mux (
                .clk_sys   (clk_sys),
                .rst       (rst),
                .req       (req),
                .cfg_rdata (cfg_rdata),
                .err_rdata (err_rdata),
                .cnt_rdata (cnt_rdata),
                .status    (status),
                .rdata     (wb_dat_r)
        );

endmodule

// File: logic/mmu_tx_read_mux.sv
`timescale 1ns/1ns

module mmu_tx_read_mux (
        input  logic                         clk_sys,
        input  logic                         rst,
        input  mmu_tx_reg_pkg::reg_req_t     req,
        input  mmu_tx_reg_pkg::reg_data_t    cfg_rdata,
        input  mmu_tx_reg_pkg::reg_data_t    err_rdata,
        input  mmu_tx_reg_pkg::reg_data_t    cnt_rdata,
        input  mmu_tx_reg_pkg::tx_status_t   status,
        output mmu_tx_reg_pkg::reg_data_t    rdata
);

        import mmu_tx_reg_pkg::*;

        reg_data_t  sta_sel;
        reg_data_t  cfg_q;
        reg_data_t  err_q;
        reg_data_t  sta_q;
        reg_data_t  cnt_q;
        reg_group_e group_q;
        logic       rd_vld_q;

        // status fields in struct order, zero-extended
        always_comb begin
                case (req.index)
                7'd0:    sta_sel = status.pkt_sta;
                7'd1:    sta_sel = {16'd0, status.bd_sta};
                7'd2:    sta_sel = {21'd0, status.ddr_rsp_sn};
                7'd3:    sta_sel = {29'd0, status.seq_info};
                7'd4:    sta_sel = {21'd0, status.online_beat};
                7'd5:    sta_sel = {21'd0, status.hacc_sn};
                default: sta_sel = '0;
                endcase
        end

        //**************************************************
        // stage 1, per group
        //**************************************************
        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        rd_vld_q <= 1'b0;
                        group_q  <= grp_cfg;
                end else begin
                        rd_vld_q <= req.valid && !req.write;
                        group_q  <= req.group;
                end
        end

        always_ff @(posedge clk_sys) begin
                if (req.valid) begin
                        cfg_q <= cfg_rdata;
                        err_q <= err_rdata;
                        sta_q <= sta_sel;
                        cnt_q <= cnt_rdata;
                end
        end

        //**************************************************
        // stage 2, group select
        //**************************************************
        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        rdata <= '0;
                end else if (!rd_vld_q) begin
                        rdata <= '0;
                end else begin
                        case (group_q)
                        grp_cfg: rdata <= cfg_q;
                        grp_err: rdata <= err_q;
                        grp_sta: rdata <= sta_q;
                        default: rdata <= cnt_q;
                        endcase
                end
        end

endmodule

// File: logic/mmu_tx_event_counters.sv
`timescale 1ns/1ns

module mmu_tx_event_counters #(
        parameter int DDR_NUM = 4
) (
        input  logic                         clk_sys,
        input  logic                         rst,
        input  logic                         cnt_clr,
        input  mmu_tx_reg_pkg::tx_events_t   events,
        input  mmu_tx_reg_pkg::ddr_events_t  ddr_events [DDR_NUM],
        input  mmu_tx_reg_pkg::reg_index_t   rd_index,
        output mmu_tx_reg_pkg::reg_data_t    cnt_rdata
);

        import mmu_tx_reg_pkg::*;

        localparam int N_TX  = $bits(tx_events_t);
        localparam int N_DDR = $bits(ddr_events_t);
        localparam int N_CNT = N_TX + N_DDR * DDR_NUM;

        logic [N_CNT-1:0] inc;
        reg_data_t        cnt [N_CNT];

        // flat counter number to register index
        function automatic reg_index_t cnt_index(input int n);
                if (n < N_TX) begin
                        return reg_index_t'(n);
                end
                return reg_index_t'(CNT_DDR_BASE + (n - N_TX));
        endfunction

        // single events first, then channel sets of four
        always_comb begin
                inc[N_TX-1:0] = events;
                for (int c = 0; c < DDR_NUM; c++) begin
                        inc[N_TX + N_DDR * c +: N_DDR] = ddr_events[c];
                end
        end

        //**************************************************
        // counters
        //**************************************************
        // wrap at 2^32, clear wins over an increment
        for (genvar n = 0; n < N_CNT; n++) begin : g_cnt
                always_ff @(posedge clk_sys or posedge rst) begin
                        if (rst) begin
                                cnt[n] <= '0;
                        end else if (cnt_clr) begin
                                cnt[n] <= '0;
                        end else if (inc[n]) begin
                                cnt[n] <= cnt[n] + 32'd1;
                        end
                end
        end

        // unmapped index reads zero
        always_comb begin
                cnt_rdata = '0;
                for (int n = 0; n < N_CNT; n++) begin
                        if (rd_index == cnt_index(n)) begin
                                cnt_rdata = cnt[n];
                        end
                end
        end

endmodule

// File: logic/mmu_tx_cfg_err_regs.sv
`timescale 1ns/1ns

module mmu_tx_cfg_err_regs (
        input  logic                         clk_sys,
        input  logic                         rst,
        input  mmu_tx_reg_pkg::reg_req_t     req,
        input  mmu_tx_reg_pkg::tx_errors_t   errors,
        output logic [10:0]                  online_beat_cfg,
        output mmu_tx_reg_pkg::reg_data_t    cfg_rdata,
        output mmu_tx_reg_pkg::reg_data_t    err_rdata
);

        import mmu_tx_reg_pkg::*;

        logic        cfg_wr;
        logic        err_wr;
        logic [31:0] pkt_err_q;
        logic [15:0] bd_err_q;
        logic [31:0] pkt_clr;
        logic [15:0] bd_clr;

        assign cfg_wr  = req.valid && req.write && (req.group == grp_cfg) &&
                         (req.index == 7'd0);
        assign err_wr  = req.valid && req.write && (req.group == grp_err);

        // write one to clear
        assign pkt_clr = (err_wr && (req.index == 7'd0)) ? req.wdata : 32'd0;
        assign bd_clr  = (err_wr && (req.index == 7'd1)) ? req.wdata[15:0] : 16'd0;

        //**************************************************
        // cfg
        //**************************************************
        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        online_beat_cfg <= ONLINE_BEAT_RESET;
                end else if (cfg_wr) begin
                        online_beat_cfg <= req.wdata[10:0];
                end
        end

        //**************************************************
        // err
        //**************************************************
        // a flag in the same cycle as its clear keeps the bit set
        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        pkt_err_q <= '0;
                        bd_err_q  <= '0;
                end else begin
                        pkt_err_q <= (pkt_err_q & ~pkt_clr) | errors.pkt_err;
                        bd_err_q  <= (bd_err_q & ~bd_clr) | errors.bd_err;
                end
        end

        assign cfg_rdata = (req.index == 7'd0) ? {21'd0, online_beat_cfg} : '0;

        always_comb begin
                case (req.index)
                7'd0:    err_rdata = pkt_err_q;
                7'd1:    err_rdata = {16'd0, bd_err_q};
                default: err_rdata = '0;
                endcase
        end

endmodule

// File: logic/mmu_tx_bus_port.sv
`timescale 1ns/1ns

module mmu_tx_bus_port #(
        parameter mmu_tx_reg_pkg::block_id_t BLOCK_ID = 12'h001
) (
        input  logic                         clk_sys,
        input  logic                         rst,
        input  logic                         wb_cyc,
        input  logic                         wb_stb,
        input  logic                         wb_we,
        input  mmu_tx_reg_pkg::reg_addr_t    wb_adr,
        input  mmu_tx_reg_pkg::reg_data_t    wb_dat_w,
        output logic                         wb_ack,
        output mmu_tx_reg_pkg::reg_req_t     req
);

        import mmu_tx_reg_pkg::*;

        bus_state_e state;
        logic       addr_hit;
        logic       bus_req;

        assign bus_req  = wb_cyc && wb_stb;

        // foreign block or nonzero reserved bits still get an ack
        assign addr_hit = (wb_adr.block_id == BLOCK_ID) && (wb_adr.rsvd == 3'd0);

        //**************************************************
        // transaction sequencing
        //**************************************************
        // writes ack right away, reads wait for the two mux stages
        always_ff @(posedge clk_sys or posedge rst) begin
                if (rst) begin
                        state <= st_idle;
                        req   <= '0;
                end else begin
                        req.valid <= 1'b0;
                        case (state)
                        st_idle: begin
                                if (bus_req) begin
                                        req.valid <= addr_hit;
                                        req.write <= wb_we;
                                        req.group <= wb_adr.group;
                                        req.index <= wb_adr.index;
                                        req.wdata <= wb_dat_w;
                                        if (wb_we) begin
                                                state <= st_ack;
                                        end else begin
                                                state <= st_rd_wait1;
                                        end
                                end
                        end
                        st_rd_wait1: begin
                                state <= st_rd_wait2;
                        end
                        st_rd_wait2: begin
                                state <= st_ack;
                        end
                        default: begin
                                // single ack cycle, master drops stb after it
                                state <= st_idle;
                        end
                        endcase
                end
        end

        assign wb_ack = (state == st_ack);

endmodule

// File: logic/mmu_tx_reg_pkg.sv
package mmu_tx_reg_pkg;

        //**************************************************
        // address fields
        //**************************************************
        typedef logic [11:0] block_id_t;
        typedef logic [6:0]  reg_index_t;
        typedef logic [31:0] reg_data_t;

        typedef enum logic [1:0] {
                grp_cfg = 2'd0,
                grp_err = 2'd1,
                grp_sta = 2'd2,
                grp_cnt = 2'd3
        } reg_group_e;

        // block id, three zero bits, group, index
        typedef struct packed {
                block_id_t  block_id;
                logic [2:0] rsvd;
                reg_group_e group;
                reg_index_t index;
        } reg_addr_t;

        typedef enum logic [1:0] {
                st_idle,
                st_rd_wait1,
                st_rd_wait2,
                st_ack
        } bus_state_e;

        typedef struct packed {
                logic       valid;
                logic       write;
                reg_group_e group;
                reg_index_t index;
                reg_data_t  wdata;
        } reg_req_t;

        //**************************************************
        // datapath side
        //**************************************************
        typedef struct packed {
                logic [31:0] pkt_sta;
                logic [15:0] bd_sta;
                logic [10:0] ddr_rsp_sn;
                logic [2:0]  seq_info;
                logic [10:0] online_beat;
                logic [10:0] hacc_sn;
        } tx_status_t;

        // declared high to low so that bit n is counter index n
        typedef struct packed {
                logic tx2rx_rd_bd;
                logic tx2rx_wr_bd;
                logic tx2rx_bd;
                logic pkt_rx;
                logic hacc_rx;
                logic axis_rx;
                logic kernel_bd_wen;
                logic ddr_rsp;
                logic rxffc_wr;
                logic fifo_rd;
                logic bd_cnt;
        } tx_events_t;

        // bit k is the counter kind k of a channel
        typedef struct packed {
                logic wlast;
                logic rsp_ok;
                logic send_ok;
                logic slice_sent;
        } ddr_events_t;

        typedef struct packed {
                logic [31:0] pkt_err;
                logic [15:0] bd_err;
        } tx_errors_t;

        localparam logic [10:0] ONLINE_BEAT_RESET = 11'h350;

        // channel c, kind k at CNT_DDR_BASE + 4*c + k
        localparam reg_index_t  CNT_DDR_BASE = 7'h10;

endpackage
